/* source/wb_pkg.sv */
// wishbone subsystem package: bus types, register map and interrupt width
package wb_pkg;

	// bus widths
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	// one select bit per byte lane
	typedef logic [3:0] wb_sel_t;

	// interrupt status and set register width
	localparam int INT_W = 8;

	// register block word offsets, taken from adr[3:2]
	localparam logic [1:0] REG_SCRATCH    = 2'd0;
	localparam logic [1:0] REG_INT_STATUS = 2'd1;
	localparam logic [1:0] REG_INT_SET    = 2'd2;
	localparam logic [1:0] REG_ID         = 2'd3;

	// value returned by the read-only id register
	localparam wb_dat_t BLOCK_ID = 32'h5742_A001;

endpackage

/* source/wishbone_arbitrator.sv */
// two-master wishbone arbiter with registered fixed-priority grant and response steering
`timescale 1ns/1ps

module wishbone_arbitrator
	import wb_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst,

	// master 0
	input  logic    m0_cyc_i,
	input  logic    m0_stb_i,
	input  logic    m0_we_i,
	input  wb_sel_t m0_sel_i,
	input  wb_adr_t m0_adr_i,
	input  wb_dat_t m0_dat_i,
	output logic    m0_ack_o,
	output wb_dat_t m0_dat_o,
	output logic    m0_int_o,

	// master 1
	input  logic    m1_cyc_i,
	input  logic    m1_stb_i,
	input  logic    m1_we_i,
	input  wb_sel_t m1_sel_i,
	input  wb_adr_t m1_adr_i,
	input  wb_dat_t m1_dat_i,
	output logic    m1_ack_o,
	output wb_dat_t m1_dat_o,
	output logic    m1_int_o,

	// shared slave side
	output logic    s_cyc_o,
	output logic    s_stb_o,
	output logic    s_we_o,
	output wb_sel_t s_sel_o,
	output wb_adr_t s_adr_o,
	output wb_dat_t s_dat_o,
	input  logic    s_ack_i,
	input  wb_dat_t s_dat_i,
	input  logic    s_int_i
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_M0,
		GNT_M1
	} grant_t;

	grant_t grant;

	// grant register, fixed priority only when idle
	always_ff @(posedge clk_i) begin
		if (rst) begin
			grant <= GNT_NONE;
		end else begin
			case (grant)
				// held until the owner drops cyc
				GNT_M0: if (!m0_cyc_i) grant <= GNT_NONE;
				GNT_M1: if (!m1_cyc_i) grant <= GNT_NONE;
				default: begin
					// master 0 wins a tie
					if (m0_cyc_i) begin
						grant <= GNT_M0;
					end else if (m1_cyc_i) begin
						grant <= GNT_M1;
					end
				end
			endcase
		end
	end

	// request mux, zeros when nobody owns the bus
	always_comb begin
		s_cyc_o = 1'b0;
		s_stb_o = 1'b0;
		s_we_o  = 1'b0;
		s_sel_o = '0;
		s_adr_o = '0;
		s_dat_o = '0;
		case (grant)
			GNT_M0: begin
				s_cyc_o = m0_cyc_i;
				s_stb_o = m0_stb_i;
				s_we_o  = m0_we_i;
				s_sel_o = m0_sel_i;
				s_adr_o = m0_adr_i;
				s_dat_o = m0_dat_i;
			end
			GNT_M1: begin
				s_cyc_o = m1_cyc_i;
				s_stb_o = m1_stb_i;
				s_we_o  = m1_we_i;
				s_sel_o = m1_sel_i;
				s_adr_o = m1_adr_i;
				s_dat_o = m1_dat_i;
			end
			default: ;
		endcase
	end

	// ack and read data only to the owner
	assign m0_ack_o = (grant == GNT_M0) ? s_ack_i : 1'b0;
	assign m0_dat_o = (grant == GNT_M0) ? s_dat_i : '0;
	assign m1_ack_o = (grant == GNT_M1) ? s_ack_i : 1'b0;
	assign m1_dat_o = (grant == GNT_M1) ? s_dat_i : '0;

	// interrupt goes to both masters regardless of grant
	assign m0_int_o = s_int_i;
	assign m1_int_o = s_int_i;

endmodule

/* source/wb_addr_decoder.sv */
// wishbone address decoder: one address bit picks the memory or the register block
`timescale 1ns/1ps

module wb_addr_decoder
	import wb_pkg::*;
#(
	parameter int DEC_BIT = 16
) (
	// from the arbiter
	input  logic    s_cyc_i,
	input  logic    s_stb_i,
	input  logic    s_we_i,
	input  wb_sel_t s_sel_i,
	input  wb_adr_t s_adr_i,
	input  wb_dat_t s_dat_i,
	output logic    s_ack_o,
	output wb_dat_t s_dat_o,

	// memory slave
	output logic    mem_cyc_o,
	output logic    mem_stb_o,
	output logic    mem_we_o,
	output wb_sel_t mem_sel_o,
	output wb_adr_t mem_adr_o,
	output wb_dat_t mem_dat_o,
	input  logic    mem_ack_i,
	input  wb_dat_t mem_dat_i,

	// register slave
	output logic    reg_cyc_o,
	output logic    reg_stb_o,
	output logic    reg_we_o,
	output wb_sel_t reg_sel_o,
	output wb_adr_t reg_adr_o,
	output wb_dat_t reg_dat_o,
	input  logic    reg_ack_i,
	input  wb_dat_t reg_dat_i
);

	// high selects the register block
	logic reg_hit;

	assign reg_hit = s_adr_i[DEC_BIT];

	// only the chosen slave sees cyc and stb
	assign mem_cyc_o = s_cyc_i & ~reg_hit;
	assign mem_stb_o = s_stb_i & ~reg_hit;
	assign reg_cyc_o = s_cyc_i & reg_hit;
	assign reg_stb_o = s_stb_i & reg_hit;

	// rest of the request fans out unchanged
	assign mem_we_o  = s_we_i;
	assign mem_sel_o = s_sel_i;
	assign mem_adr_o = s_adr_i;
	assign mem_dat_o = s_dat_i;
	assign reg_we_o  = s_we_i;
	assign reg_sel_o = s_sel_i;
	assign reg_adr_o = s_adr_i;
	assign reg_dat_o = s_dat_i;

	// response from the selected slave
	assign s_ack_o = reg_hit ? reg_ack_i : mem_ack_i;
	assign s_dat_o = reg_hit ? reg_dat_i : mem_dat_i;

endmodule

/* source/wb_mem_slave.sv */
// wishbone word memory slave with byte-lane writes and registered ack
`timescale 1ns/1ps

module wb_mem_slave
	import wb_pkg::*;
#(
	parameter int MEM_AW = 8
) (
	input  logic    clk_i,
	input  logic    rst,
	input  logic    cyc_i,
	input  logic    stb_i,
	input  logic    we_i,
	input  wb_sel_t sel_i,
	input  wb_adr_t adr_i,
	input  wb_dat_t dat_i,
	output logic    ack_o,
	output wb_dat_t dat_o
);

	localparam int DEPTH = 1 << MEM_AW;

	wb_dat_t           mem [DEPTH];
	logic [MEM_AW-1:0] word_idx;
	logic              access;

	// byte address to word index
	assign word_idx = adr_i[MEM_AW+1:2];

	// new transfer, not the tail of one already acked
	assign access = cyc_i & stb_i & ~ack_o;

	// one-cycle ack
	always_ff @(posedge clk_i) begin
		if (rst) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	// lane writes land with the rising ack
	always_ff @(posedge clk_i) begin
		if (access && we_i) begin
			for (int b = 0; b < 4; b++) begin
				if (sel_i[b]) begin
					mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
		end
	end

	// read data valid together with ack
	always_ff @(posedge clk_i) begin
		if (access) begin
			dat_o <= mem[word_idx];
		end
	end

endmodule

/* source/wb_reg_slave.sv */
// wishbone register block: scratch, interrupt status and set, id, with interrupt output
`timescale 1ns/1ps

module wb_reg_slave
	import wb_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst,
	input  logic    cyc_i,
	input  logic    stb_i,
	input  logic    we_i,
	input  wb_sel_t sel_i,
	input  wb_adr_t adr_i,
	input  wb_dat_t dat_i,
	output logic    ack_o,
	output wb_dat_t dat_o,
	output logic    int_o
);

	wb_dat_t          scratch;
	logic [INT_W-1:0] int_status;
	logic [1:0]       offset;
	logic             access;

	assign offset = adr_i[3:2];
	assign access = cyc_i & stb_i & ~ack_o;

	// ack, scratch and status writes
	always_ff @(posedge clk_i) begin
		if (rst) begin
			ack_o      <= 1'b0;
			scratch    <= '0;
			int_status <= '0;
		end else begin
			ack_o <= access;
			if (access && we_i) begin
				case (offset)
					REG_SCRATCH: begin
						for (int b = 0; b < 4; b++) begin
							if (sel_i[b]) scratch[8*b +: 8] <= dat_i[8*b +: 8];
						end
					end
					// write one to clear
					REG_INT_STATUS: int_status <= int_status & ~dat_i[INT_W-1:0];
					// or into status
					REG_INT_SET: int_status <= int_status | dat_i[INT_W-1:0];
					// id is read-only
					default: ;
				endcase
			end
		end
	end

	// registered read mux, set register reads zero
	always_ff @(posedge clk_i) begin
		if (access) begin
			case (offset)
				REG_SCRATCH:    dat_o <= scratch;
				REG_INT_STATUS: dat_o <= wb_dat_t'(int_status);
				REG_ID:         dat_o <= BLOCK_ID;
				default:        dat_o <= '0;
			endcase
		end
	end

	// any pending status bit raises the line
	assign int_o = |int_status;

endmodule

/* source/wb_arb_top.sv */
// two-master wishbone subsystem top: arbiter, address decoder, memory and register slaves
`timescale 1ns/1ps

module wb_arb_top
	import wb_pkg::*;
#(
	parameter int MEM_AW  = 8,
	parameter int DEC_BIT = 16
) (
	input  logic    clk_i,
	input  logic    rst,

	// master 0
	input  logic    m0_cyc_i,
	input  logic    m0_stb_i,
	input  logic    m0_we_i,
	input  wb_sel_t m0_sel_i,
	input  wb_adr_t m0_adr_i,
	input  wb_dat_t m0_dat_i,
	output logic    m0_ack_o,
	output wb_dat_t m0_dat_o,
	output logic    m0_int_o,

	// master 1
	input  logic    m1_cyc_i,
	input  logic    m1_stb_i,
	input  logic    m1_we_i,
	input  wb_sel_t m1_sel_i,
	input  wb_adr_t m1_adr_i,
	input  wb_dat_t m1_dat_i,
	output logic    m1_ack_o,
	output wb_dat_t m1_dat_o,
	output logic    m1_int_o
);

	// shared bus after the arbiter
	logic    s_cyc, s_stb, s_we, s_ack;
	wb_sel_t s_sel;
	wb_adr_t s_adr;
	wb_dat_t s_wdat, s_rdat;
	logic    reg_int;

	// memory branch
	logic    mem_cyc, mem_stb, mem_we, mem_ack;
	wb_sel_t mem_sel;
	wb_adr_t mem_adr;
	wb_dat_t mem_wdat, mem_rdat;

	// register branch
	logic    reg_cyc, reg_stb, reg_we, reg_ack;
	wb_sel_t reg_sel;
	wb_adr_t reg_adr;
	wb_dat_t reg_wdat, reg_rdat;

	wishbone_arbitrator i_arb (
		.clk_i, .rst,
		.m0_cyc_i, .m0_stb_i, .m0_we_i, .m0_sel_i, .m0_adr_i, .m0_dat_i,
		.m0_ack_o, .m0_dat_o, .m0_int_o,
		.m1_cyc_i, .m1_stb_i, .m1_we_i, .m1_sel_i, .m1_adr_i, .m1_dat_i,
		.m1_ack_o, .m1_dat_o, .m1_int_o,
		.s_cyc_o (s_cyc),  .s_stb_o (s_stb),  .s_we_o  (s_we),
		.s_sel_o (s_sel),  .s_adr_o (s_adr),  .s_dat_o (s_wdat),
		.s_ack_i (s_ack),  .s_dat_i (s_rdat), .s_int_i (reg_int)
	);

	wb_addr_decoder #(.DEC_BIT(DEC_BIT)) i_dec (
		.s_cyc_i   (s_cyc),   .s_stb_i   (s_stb),   .s_we_i    (s_we),
		.s_sel_i   (s_sel),   .s_adr_i   (s_adr),   .s_dat_i   (s_wdat),
		.s_ack_o   (s_ack),   .s_dat_o   (s_rdat),
		.mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_we_o  (mem_we),
		.mem_sel_o (mem_sel), .mem_adr_o (mem_adr), .mem_dat_o (mem_wdat),
		.mem_ack_i (mem_ack), .mem_dat_i (mem_rdat),
		.reg_cyc_o (reg_cyc), .reg_stb_o (reg_stb), .reg_we_o  (reg_we),
		.reg_sel_o (reg_sel), .reg_adr_o (reg_adr), .reg_dat_o (reg_wdat),
		.reg_ack_i (reg_ack), .reg_dat_i (reg_rdat)
	);

	wb_mem_slave #(.MEM_AW(MEM_AW)) i_mem (
		.clk_i, .rst,
		.cyc_i (mem_cyc), .stb_i (mem_stb), .we_i  (mem_we),
		.sel_i (mem_sel), .adr_i (mem_adr), .dat_i (mem_wdat),
		.ack_o (mem_ack), .dat_o (mem_rdat)
	);

	wb_reg_slave i_regs (
		.clk_i, .rst,
		.cyc_i (reg_cyc), .stb_i (reg_stb), .we_i  (reg_we),
		.sel_i (reg_sel), .adr_i (reg_adr), .dat_i (reg_wdat),
		.ack_o (reg_ack), .dat_o (reg_rdat), .int_o (reg_int)
	);

endmodule

/* testbench/wb_arb_props.sv */
// arbiter properties: ack exclusivity, ack only to an active master, stb inside cyc
`timescale 1ns/1ps

module wb_arb_props (
	input logic clk_i,
	input logic rst,
	input logic m0_cyc_i,
	input logic m1_cyc_i,
	input logic m0_ack_o,
	input logic m1_ack_o,
	input logic s_cyc_o,
	input logic s_stb_o
);

	// read by the testbench at the end of the run
	int assert_fails = 0;

	// one owner, so never two acks at once
	ack_exclusive: assert property (@(posedge clk_i) disable iff (rst)
		!(m0_ack_o && m1_ack_o))
		else begin
			$error("m0_ack_o and m1_ack_o high in the same cycle");
			assert_fails++;
		end

	// ack only to a master still in its cycle
	m0_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst) m0_ack_o |-> m0_cyc_i)
		else begin
			$error("m0_ack_o high while m0_cyc_i is low");
			assert_fails++;
		end

	m1_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst) m1_ack_o |-> m1_cyc_i)
		else begin
			$error("m1_ack_o high while m1_cyc_i is low");
			assert_fails++;
		end

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst) s_stb_o |-> s_cyc_o)
		else begin
			$error("s_stb_o high without s_cyc_o");
			assert_fails++;
		end

endmodule

bind wishbone_arbitrator wb_arb_props i_props (.*);

/* testbench/wb_arb_tb.sv */
// testbench for the two-master wishbone subsystem: random masters checked against a model
`timescale 1ns/1ps

module wb_arb_tb
	import wb_pkg::*;
();

	localparam int          MEM_AW       = 8;
	localparam int          DEC_BIT      = 16;
	localparam int          CLK_PERIOD   = 40;
	localparam int          N_XFER       = 200;
	localparam int          TEST_WORDS   = 32;
	// worst case per transfer: idle gap, one foreign transfer, own handshake
	localparam int          CYC_PER_XFER = 16;
	localparam int          TIMEOUT_NS   = (2 * N_XFER + 20) * CYC_PER_XFER * CLK_PERIOD;
	localparam logic [31:0] SEED         = 32'h5447f0d5;
	localparam wb_adr_t     REG_BASE     = wb_adr_t'(1) << DEC_BIT;

	logic              clk_i;
	logic              rst;
	logic [1:0]        cyc, stb, we;
	wb_sel_t [1:0]     sel;
	wb_adr_t [1:0]     adr;
	wb_dat_t [1:0]     wdat;
	wire [1:0]         ack, irq;
	wire [1:0][31:0]   rdat;

	// reference model
	wb_dat_t           model_mem [1 << MEM_AW];
	logic [3:0]        model_vld [1 << MEM_AW];
	wb_dat_t           model_scratch = '0;
	logic [INT_W-1:0]  model_status  = '0;

	int                mism_errs = 0;
	int                other_errs = 0;
	int                xfer_cnt [2] = '{0, 0};
	int                ack_seen [2] = '{0, 0};
	int                cycle = 0;

	wb_arb_top #(.MEM_AW(MEM_AW), .DEC_BIT(DEC_BIT)) i_dut (
		.clk_i, .rst,
		.m0_cyc_i (cyc[0]), .m0_stb_i (stb[0]), .m0_we_i  (we[0]),
		.m0_sel_i (sel[0]), .m0_adr_i (adr[0]), .m0_dat_i (wdat[0]),
		.m0_ack_o (ack[0]), .m0_dat_o (rdat[0]), .m0_int_o (irq[0]),
		.m1_cyc_i (cyc[1]), .m1_stb_i (stb[1]), .m1_we_i  (we[1]),
		.m1_sel_i (sel[1]), .m1_adr_i (adr[1]), .m1_dat_i (wdat[1]),
		.m1_ack_o (ack[1]), .m1_dat_o (rdat[1]), .m1_int_o (irq[1])
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
		// every ack pulse, to catch a second ack for one transfer
		if (!rst && ack[0]) ack_seen[0] <= ack_seen[0] + 1;
		if (!rst && ack[1]) ack_seen[1] <= ack_seen[1] + 1;
	end

	function automatic wb_adr_t reg_adr(input logic [1:0] off);
		return REG_BASE | (wb_adr_t'(off) << 2);
	endfunction

	// apply one acked transfer to the model, in ack order, and check it
	function automatic void model_access(input int m, input logic w, input wb_adr_t a,
		input wb_sel_t s, input wb_dat_t d, input wb_dat_t q);
		wb_dat_t exp;
		wb_dat_t mask;
		int      idx;
		exp  = '0;
		mask = '1;
		idx  = int'(a[MEM_AW+1:2]);
		if (!a[DEC_BIT]) begin
			exp = model_mem[idx];
			for (int b = 0; b < 4; b++) begin
				// lanes never written hold no known value
				mask[8*b +: 8] = {8{model_vld[idx][b]}};
				if (w && s[b]) begin
					model_mem[idx][8*b +: 8] = d[8*b +: 8];
					model_vld[idx][b] = 1'b1;
				end
			end
		end else begin
			case (a[3:2])
				REG_SCRATCH: begin
					exp = model_scratch;
					for (int b = 0; b < 4; b++) begin
						if (w && s[b]) model_scratch[8*b +: 8] = d[8*b +: 8];
					end
				end
				REG_INT_STATUS: begin
					exp = wb_dat_t'(model_status);
					if (w) model_status = model_status & ~d[INT_W-1:0];
				end
				REG_INT_SET: begin
					if (w) model_status = model_status | d[INT_W-1:0];
				end
				default: exp = BLOCK_ID;
			endcase
		end
		if (!w && ((q & mask) !== (exp & mask))) begin
			$display("mismatch m%0d_dat_o at adr %h: expected %h, got %h", m, a,
				exp & mask, q & mask);
			mism_errs++;
		end
		// interrupt reaches both masters at once
		if (irq !== {2{model_status != '0}}) begin
			$display("mismatch m1_int_o/m0_int_o: expected %h, got %h",
				{2{model_status != '0}}, irq);
			mism_errs++;
		end
	endfunction

	// one classic single transfer, entered and left on a rising edge
	task automatic bus_transfer(input int m, input logic w, input wb_adr_t a,
		input wb_sel_t s, input wb_dat_t d, output wb_dat_t q, output int ack_at);
		cyc[m]  <= 1'b1;
		stb[m]  <= 1'b1;
		we[m]   <= w;
		sel[m]  <= s;
		adr[m]  <= a;
		wdat[m] <= d;
		do @(posedge clk_i); while (!ack[m]);
		q      = rdat[m];
		ack_at = cycle;
		cyc[m] <= 1'b0;
		stb[m] <= 1'b0;
		we[m]  <= 1'b0;
		xfer_cnt[m]++;
		model_access(m, w, a, s, d, q);
	endtask

	task automatic master_run(input int m);
		wb_adr_t a;
		wb_dat_t q;
		logic    w;
		int      t;
		for (int i = 0; i < N_XFER; i++) begin
			// at least one idle cycle so the grant can move
			repeat (1 + $urandom_range(0, 3)) @(posedge clk_i);
			w = $urandom_range(0, 1);
			if ($urandom_range(0, 3) == 0) a = reg_adr($urandom_range(0, 3));
			else a = wb_adr_t'($urandom_range(0, TEST_WORDS - 1)) << 2;
			bus_transfer(m, w, a, wb_sel_t'($urandom_range(1, 15)), $urandom, q, t);
		end
	endtask

	initial begin
		wb_dat_t q0, q1;
		int      t0, t1;
		void'($urandom(SEED));
		for (int i = 0; i < (1 << MEM_AW); i++) model_vld[i] = 4'h0;
		rst  = 1'b1;
		cyc  = '0;
		stb  = '0;
		we   = '0;
		sel  = '0;
		adr  = '0;
		wdat = '0;
		repeat (4) @(posedge clk_i);
		rst <= 1'b0;
		@(posedge clk_i);
		if (ack !== 2'b00) begin
			$display("mismatch m1_ack_o/m0_ack_o after reset: expected 0, got %h", ack);
			mism_errs++;
		end
		if (irq !== 2'b00) begin
			$display("mismatch m1_int_o/m0_int_o after reset: expected 0, got %h", irq);
			mism_errs++;
		end
		// both masters request from an idle bus in the same cycle
		fork
			bus_transfer(0, 1'b0, reg_adr(REG_ID), 4'hf, '0, q0, t0);
			bus_transfer(1, 1'b0, reg_adr(REG_ID), 4'hf, '0, q1, t1);
		join
		if (t0 >= t1) begin
			$display("master 1 was acked before master 0 after a simultaneous request");
			other_errs++;
		end
		fork
			master_run(0);
			master_run(1);
		join
		repeat (2) @(posedge clk_i);
		// raise the interrupt, then clear exactly the pending bits
		bus_transfer(0, 1'b1, reg_adr(REG_INT_SET), 4'hf, 32'h0000_005a, q0, t0);
		repeat (2) @(posedge clk_i);
		bus_transfer(1, 1'b0, reg_adr(REG_INT_STATUS), 4'hf, '0, q1, t1);
		repeat (2) @(posedge clk_i);
		bus_transfer(0, 1'b1, reg_adr(REG_INT_STATUS), 4'hf, q1, q0, t0);
		repeat (3) @(posedge clk_i);
		for (int m = 0; m < 2; m++) begin
			if (ack_seen[m] != xfer_cnt[m]) begin
				$display("master %0d issued %0d transfers but saw %0d acks", m,
					xfer_cnt[m], ack_seen[m]);
				other_errs++;
			end
		end
		other_errs += i_dut.i_arb.i_props.assert_fails;
		$display("errors: %0d mismatch, %0d other", mism_errs, other_errs);
		if (mism_errs + other_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: transfers still pending after %0d ns", TIMEOUT_NS);
		$display("errors: %0d mismatch, %0d other", mism_errs, other_errs + 1);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* wb_arb_top.f */
source/wb_pkg.sv
source/wishbone_arbitrator.sv
source/wb_addr_decoder.sv
source/wb_mem_slave.sv
source/wb_reg_slave.sv
source/wb_arb_top.sv
testbench/wb_arb_props.sv
testbench/wb_arb_tb.sv

/* Bender.yml */
package:
  name: wb_arb

sources:
  # design
  - source/wb_pkg.sv
  - source/wishbone_arbitrator.sv
  - source/wb_addr_decoder.sv
  - source/wb_mem_slave.sv
  - source/wb_reg_slave.sv
  - source/wb_arb_top.sv

  # simulation only
  - target: test
    files:
      - testbench/wb_arb_props.sv
      - testbench/wb_arb_tb.sv
